// ==== lua_consts.svh ====
`ifndef LUA_CONSTS_SVH
`define LUA_CONSTS_SVH

`define LUA_WORD_BITS 32
`define LUA_TTAG_BITS 7
`define LUA_REG_COUNT 64
`define LUA_REG_IDX_BITS 6

// one TValue slot is 8 bytes, tag word at +4
`define LUA_TVALUE_SHIFT 3
`define LUA_TYPE_OFFSET 32'd4

// CallInfo.u.l.savedpc
`define LUA_SAVEDPC_OFFSET 32'd20
`define LUA_INSTR_BYTES 32'd4

`define LUA_T_NIL 7'd0

`endif

// ==== lua_pkg.sv ====
`default_nettype none
`include "lua_consts.svh"

package lua_pkg;

	typedef logic [`LUA_WORD_BITS-1:0] word_t;
	typedef logic [`LUA_REG_IDX_BITS-1:0] reg_idx_t;
	typedef logic [`LUA_TTAG_BITS-1:0] ttag_t;

	// Lua 5.3 opcode numbering
	typedef enum logic [5:0] {
		OP_MOVE, OP_LOADK, OP_LOADKX, OP_LOADBOOL, OP_LOADNIL, OP_GETUPVAL,
		OP_GETTABUP, OP_GETTABLE, OP_SETTABUP, OP_SETUPVAL, OP_SETTABLE, OP_NEWTABLE,
		OP_SELF, OP_ADD, OP_SUB, OP_MUL, OP_MOD, OP_POW, OP_DIV, OP_IDIV,
		OP_BAND, OP_BOR, OP_BXOR, OP_SHL, OP_SHR, OP_UNM, OP_BNOT, OP_NOT,
		OP_LEN, OP_CONCAT, OP_JMP, OP_EQ, OP_LT, OP_LE, OP_TEST, OP_TESTSET,
		OP_CALL, OP_TAILCALL, OP_RETURN, OP_FORLOOP, OP_FORPREP, OP_TFORCALL,
		OP_TFORLOOP, OP_SETLIST, OP_CLOSURE, OP_VARARG, OP_EXTRAARG
	} opcode_t;

	typedef enum logic [1:0] {IN_PROGRESS, DONE, NOT_IMPL} instr_status_t;

	typedef enum logic [1:0] {CMD_RUN, CMD_LOAD_REG, CMD_LOAD_TT, CMD_LOAD_BASE} host_cmd_t;

	typedef enum logic [1:0] {SRC_INSTR, SRC_DUMPER, SRC_EXTERNAL} a_source_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none
`include "lua_consts.svh"

module fetch_unit (
	input wire clk,
	input wire rst,
	input wire lua_pkg::word_t ci,
	input wire fetch_pc,
	input wire store_pc,
	input wire fetch_instr,
	input wire lua_pkg::word_t mem_readdata,
	input wire mem_waitrequest,
	output lua_pkg::word_t instruction,
	output logic pc_done,
	output logic ir_done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	output logic mem_read,
	output logic mem_write
);
	import lua_pkg::*;

	word_t pc;
	word_t savedpc_addr;
	logic pc_rd;
	logic pc_wr;
	logic ir_rd;

	assign savedpc_addr = ci + `LUA_SAVEDPC_OFFSET;
	assign pc_rd = fetch_pc && !pc_done; // drop request once the pulse is out
	assign pc_wr = store_pc && !pc_done;
	assign ir_rd = fetch_instr && !ir_done;

	always_comb begin
		mem_address = '0; // idle must be zero for the OR merge
		mem_writedata = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		if (ir_rd) begin
			mem_address = pc;
			mem_read = 1'b1;
		end else if (pc_rd || pc_wr) begin
			mem_address = savedpc_addr;
			mem_read = pc_rd;
			mem_write = pc_wr;
			mem_writedata = pc_wr ? pc : '0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			instruction <= '0;
			pc_done <= 1'b0;
			ir_done <= 1'b0;
		end else begin
			pc_done <= (pc_rd || pc_wr) && !mem_waitrequest;
			ir_done <= ir_rd && !mem_waitrequest;
			if (pc_rd && !mem_waitrequest) begin
				pc <= mem_readdata;
			end else if (ir_rd && !mem_waitrequest) begin
				instruction <= mem_readdata;
				pc <= pc + `LUA_INSTR_BYTES; // savedpc points past current instr
			end
		end
	end

endmodule

`default_nettype wire

// ==== instr_exec.sv ====
`default_nettype none

module instr_exec (
	input wire clk,
	input wire rst,
	input wire run_instr,
	input wire lua_pkg::word_t instruction,
	input wire lua_pkg::word_t data_b,
	input wire lua_pkg::ttag_t type_b,
	output lua_pkg::reg_idx_t idx_a,
	output lua_pkg::reg_idx_t idx_b,
	output lua_pkg::word_t wdata,
	output lua_pkg::ttag_t wtype,
	output logic wen,
	output lua_pkg::instr_status_t instr_status
);
	import lua_pkg::*;

	opcode_t opcode;
	logic fresh;

	assign opcode = opcode_t'(instruction[5:0]);
	assign idx_a = instruction[11:6]; // A is 13:6, low bits only
	assign idx_b = instruction[28:23]; // B is 31:23
	assign fresh = instr_status == IN_PROGRESS; // first cycle of run_instr
	assign wen = run_instr && fresh && opcode == OP_MOVE;
	assign wdata = data_b;
	assign wtype = type_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			instr_status <= IN_PROGRESS;
		else if (run_instr && fresh)
			instr_status <= (opcode == OP_MOVE) ? DONE : NOT_IMPL;
		else
			instr_status <= IN_PROGRESS;
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none
`include "lua_consts.svh"

module register_file (
	input wire clk,
	input wire rst,
	input wire lua_pkg::reg_idx_t idx_a,
	input wire lua_pkg::reg_idx_t idx_b,
	input wire lua_pkg::word_t wdata_a,
	input wire lua_pkg::ttag_t wtype_a,
	input wire wdata_en,
	input wire wtype_en,
	input wire mark_dirty,
	input wire clear_dirty,
	input wire clear_valid,
	output lua_pkg::word_t data_a,
	output lua_pkg::ttag_t type_a,
	output logic dirty_a,
	output logic valid_a,
	output lua_pkg::word_t data_b,
	output lua_pkg::ttag_t type_b,
	output logic any_dirty
);
	import lua_pkg::*;

	word_t data_mem [`LUA_REG_COUNT];
	ttag_t tag_mem [`LUA_REG_COUNT];
	logic [`LUA_REG_COUNT-1:0] valid;
	logic [`LUA_REG_COUNT-1:0] dirty;

	always_ff @(posedge clk) begin
		if (wdata_en)
			data_mem[idx_a] <= wdata_a;
		if (wtype_en)
			tag_mem[idx_a] <= wtype_a;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (clear_valid)
				valid <= '0;
			else if (wdata_en)
				valid[idx_a] <= 1'b1; // tag write follows data when needed
			if (clear_dirty)
				dirty <= '0;
			else if (mark_dirty && (wdata_en || wtype_en))
				dirty[idx_a] <= 1'b1; // host loads leave dirty alone
		end
	end

	assign data_a = wdata_en ? wdata_a : data_mem[idx_a]; // write bypass
	assign type_a = wtype_en ? wtype_a : tag_mem[idx_a];
	assign dirty_a = dirty[idx_a];
	assign valid_a = valid[idx_a];
	assign data_b = data_mem[idx_b];
	assign type_b = tag_mem[idx_b];
	assign any_dirty = |dirty;

endmodule

`default_nettype wire

// ==== reg_port_a_select.sv ====
`default_nettype none
`include "lua_consts.svh"

module reg_port_a_select (
	input wire clk,
	input wire rst,
	input wire write_base,
	input wire lua_pkg::a_source_t a_source,
	input wire lua_pkg::word_t dataa,
	input wire lua_pkg::word_t datab,
	input wire lua_pkg::reg_idx_t instr_idx,
	input wire lua_pkg::word_t instr_wdata,
	input wire lua_pkg::ttag_t instr_wtype,
	input wire instr_wen,
	input wire lua_pkg::reg_idx_t dump_idx,
	input wire load_data_en,
	input wire load_type_en,
	output lua_pkg::word_t base,
	output lua_pkg::reg_idx_t idx_a,
	output lua_pkg::word_t wdata_a,
	output lua_pkg::ttag_t wtype_a,
	output logic wdata_en,
	output logic wtype_en,
	output logic mark_dirty
);
	import lua_pkg::*;

	word_t host_off;
	logic host_ok;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			base <= '0;
		else if (write_base)
			base <= dataa;
	end

	assign host_off = (dataa - base) >> `LUA_TVALUE_SHIFT; // slot address to index
	assign host_ok = host_off < `LUA_REG_COUNT; // below base wraps high too
	assign mark_dirty = a_source != SRC_EXTERNAL;

	always_comb begin
		idx_a = instr_idx;
		wdata_a = instr_wdata;
		wtype_a = instr_wtype;
		wdata_en = 1'b0;
		wtype_en = 1'b0;
		case (a_source)
			SRC_INSTR: begin
				wdata_en = instr_wen;
				wtype_en = instr_wen;
			end
			SRC_DUMPER: idx_a = dump_idx; // read only
			SRC_EXTERNAL: begin
				idx_a = reg_idx_t'(host_off);
				wdata_a = datab;
				wtype_a = ttag_t'(datab);
				wdata_en = load_data_en && host_ok;
				wtype_en = load_type_en && host_ok;
			end
			default: wtype_a = `LUA_T_NIL;
		endcase
	end

endmodule

`default_nettype wire

// ==== register_dumper.sv ====
`default_nettype none
`include "lua_consts.svh"

module register_dumper (
	input wire clk,
	input wire rst,
	input wire dump_regs,
	input wire lua_pkg::word_t base,
	input wire lua_pkg::word_t data_a,
	input wire lua_pkg::ttag_t type_a,
	input wire dirty_a,
	input wire valid_a,
	input wire mem_waitrequest,
	output lua_pkg::reg_idx_t reg_idx,
	output logic dump_done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	output logic mem_write
);
	import lua_pkg::*;

	typedef enum logic [1:0] {PH_START, PH_DATA, PH_TYPE, PH_DONE} phase_t;

	phase_t phase;
	reg_idx_t cur_reg;
	word_t slot_addr;
	logic last_reg;
	logic should_write;
	logic step;

	assign reg_idx = cur_reg;
	assign last_reg = cur_reg == reg_idx_t'(`LUA_REG_COUNT - 1);
	assign should_write = dirty_a && valid_a;
	assign step = !should_write || !mem_waitrequest; // skipped slots take one cycle
	assign slot_addr = base + (word_t'(cur_reg) << `LUA_TVALUE_SHIFT);
	assign dump_done = phase == PH_DONE;

	always_comb begin
		mem_address = '0;
		mem_writedata = '0;
		mem_write = 1'b0;
		if (should_write && phase == PH_DATA) begin
			mem_address = slot_addr;
			mem_writedata = data_a;
			mem_write = 1'b1;
		end else if (should_write && phase == PH_TYPE) begin
			mem_address = slot_addr + `LUA_TYPE_OFFSET; // tt_ field
			mem_writedata = word_t'(type_a);
			mem_write = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_START;
			cur_reg <= '0;
		end else begin
			case (phase)
				PH_START: begin
					if (dump_regs) begin
						cur_reg <= '0;
						phase <= PH_DATA;
					end
				end
				PH_DATA: begin
					if (step) begin
						if (should_write)
							phase <= PH_TYPE;
						else if (last_reg)
							phase <= PH_DONE;
						else
							cur_reg <= cur_reg + 1'b1;
					end
				end
				PH_TYPE: begin
					if (step) begin
						phase <= last_reg ? PH_DONE : PH_DATA;
						cur_reg <= cur_reg + 1'b1; // wraps to 0 after the last
					end
				end
				default: phase <= PH_START;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== main_sequencer.sv ====
`default_nettype none

module main_sequencer (
	input wire clk,
	input wire rst,
	input wire start,
	input wire lua_pkg::host_cmd_t n,
	input wire pc_done,
	input wire ir_done,
	input wire lua_pkg::instr_status_t instr_status,
	input wire any_dirty,
	input wire dump_done,
	output logic fetch_pc,
	output logic store_pc,
	output logic fetch_instr,
	output logic run_instr,
	output logic dump_regs,
	output logic write_base,
	output lua_pkg::a_source_t a_source,
	output logic load_data_en,
	output logic load_type_en,
	output logic clear_dirty,
	output logic clear_valid,
	output logic done
);
	import lua_pkg::*;

	typedef enum logic [3:0] {
		EX_IDLE, EX_FETCH_PC, EX_FETCH_INSTR, EX_EXEC, EX_STORE_PC,
		EX_STORE_REGS, EX_LOAD_REG, EX_LOAD_TT, EX_LOAD_BASE, EX_FINISH
	} ex_state_t;

	ex_state_t state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= EX_IDLE;
		end else begin
			case (state)
				EX_IDLE: begin
					if (start) begin
						case (n)
							CMD_RUN: state <= EX_FETCH_PC;
							CMD_LOAD_REG: state <= EX_LOAD_REG;
							CMD_LOAD_TT: state <= EX_LOAD_TT;
							default: state <= EX_LOAD_BASE;
						endcase
					end
				end
				EX_FETCH_PC: if (pc_done) state <= EX_FETCH_INSTR;
				EX_FETCH_INSTR: if (ir_done) state <= EX_EXEC;
				EX_EXEC: begin
					if (instr_status == DONE)
						state <= EX_FETCH_INSTR;
					else if (instr_status == NOT_IMPL)
						state <= EX_STORE_PC; // hand back to the software VM
				end
				EX_STORE_PC: if (pc_done) state <= any_dirty ? EX_STORE_REGS : EX_FINISH;
				EX_STORE_REGS: if (dump_done) state <= EX_FINISH;
				EX_LOAD_REG,
				EX_LOAD_TT,
				EX_LOAD_BASE: state <= EX_FINISH;
				default: state <= EX_IDLE;
			endcase
		end
	end

	always_comb begin
		fetch_pc = state == EX_FETCH_PC;
		store_pc = state == EX_STORE_PC;
		fetch_instr = state == EX_FETCH_INSTR;
		run_instr = state == EX_EXEC;
		dump_regs = state == EX_STORE_REGS;
		write_base = state == EX_LOAD_BASE;
		load_data_en = state == EX_LOAD_REG;
		load_type_en = state == EX_LOAD_TT;
		clear_dirty = state == EX_FINISH || state == EX_LOAD_BASE;
		clear_valid = state == EX_LOAD_BASE; // new frame, old contents stale
		done = state == EX_FINISH;
		a_source = SRC_INSTR;
		if (state == EX_STORE_REGS)
			a_source = SRC_DUMPER;
		else if (state == EX_LOAD_REG || state == EX_LOAD_TT)
			a_source = SRC_EXTERNAL;
	end

endmodule

`default_nettype wire

// ==== lua_cpu.sv ====
`default_nettype none

module lua_cpu (
	input wire clk,
	input wire rst,
	input wire start,
	input wire lua_pkg::host_cmd_t n,
	input wire lua_pkg::word_t dataa,
	input wire lua_pkg::word_t datab,
	input wire lua_pkg::word_t mem_readdata,
	input wire mem_waitrequest,
	output lua_pkg::word_t result,
	output logic done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	output logic mem_read,
	output logic mem_write
);
	import lua_pkg::*;

	word_t fu_addr;
	word_t fu_wdata;
	logic fu_read;
	logic fu_write;
	logic pc_done;
	logic ir_done;
	logic fetch_pc;
	logic store_pc;
	logic fetch_instr;
	logic run_instr;
	logic dump_regs;
	logic write_base;
	a_source_t a_source;
	logic load_data_en;
	logic load_type_en;
	logic clear_dirty;
	logic clear_valid;
	reg_idx_t ex_idx_a;
	reg_idx_t ex_idx_b;
	word_t ex_wdata;
	ttag_t ex_wtype;
	logic ex_wen;
	instr_status_t instr_status;
	word_t base;
	reg_idx_t idx_a;
	word_t wdata_a;
	ttag_t wtype_a;
	logic wdata_en;
	logic wtype_en;
	logic mark_dirty;
	word_t data_a;
	ttag_t type_a;
	logic dirty_a;
	logic valid_a;
	word_t data_b;
	ttag_t type_b;
	logic any_dirty;
	reg_idx_t dump_idx;
	logic dump_done;
	word_t dump_addr;
	word_t dump_wdata;
	logic dump_write;

	main_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.n(n),
		.pc_done(pc_done),
		.ir_done(ir_done),
		.instr_status(instr_status),
		.any_dirty(any_dirty),
		.dump_done(dump_done),
		.fetch_pc(fetch_pc),
		.store_pc(store_pc),
		.fetch_instr(fetch_instr),
		.run_instr(run_instr),
		.dump_regs(dump_regs),
		.write_base(write_base),
		.a_source(a_source),
		.load_data_en(load_data_en),
		.load_type_en(load_type_en),
		.clear_dirty(clear_dirty),
		.clear_valid(clear_valid),
		.done(done)
	);

	fetch_unit u_fetch (
		.clk(clk),
		.rst(rst),
		.ci(datab), // CallInfo pointer during run
		.fetch_pc(fetch_pc),
		.store_pc(store_pc),
		.fetch_instr(fetch_instr),
		.mem_readdata(mem_readdata),
		.mem_waitrequest(mem_waitrequest),
		.instruction(result),
		.pc_done(pc_done),
		.ir_done(ir_done),
		.mem_address(fu_addr),
		.mem_writedata(fu_wdata),
		.mem_read(fu_read),
		.mem_write(fu_write)
	);

	instr_exec u_exec (
		.clk(clk),
		.rst(rst),
		.run_instr(run_instr),
		.instruction(result),
		.data_b(data_b),
		.type_b(type_b),
		.idx_a(ex_idx_a),
		.idx_b(ex_idx_b),
		.wdata(ex_wdata),
		.wtype(ex_wtype),
		.wen(ex_wen),
		.instr_status(instr_status)
	);

	reg_port_a_select u_asel (
		.clk(clk),
		.rst(rst),
		.write_base(write_base),
		.a_source(a_source),
		.dataa(dataa),
		.datab(datab),
		.instr_idx(ex_idx_a),
		.instr_wdata(ex_wdata),
		.instr_wtype(ex_wtype),
		.instr_wen(ex_wen),
		.dump_idx(dump_idx),
		.load_data_en(load_data_en),
		.load_type_en(load_type_en),
		.base(base),
		.idx_a(idx_a),
		.wdata_a(wdata_a),
		.wtype_a(wtype_a),
		.wdata_en(wdata_en),
		.wtype_en(wtype_en),
		.mark_dirty(mark_dirty)
	);

	register_file u_rf (
		.clk(clk),
		.rst(rst),
		.idx_a(idx_a),
		.idx_b(ex_idx_b),
		.wdata_a(wdata_a),
		.wtype_a(wtype_a),
		.wdata_en(wdata_en),
		.wtype_en(wtype_en),
		.mark_dirty(mark_dirty),
		.clear_dirty(clear_dirty),
		.clear_valid(clear_valid),
		.data_a(data_a),
		.type_a(type_a),
		.dirty_a(dirty_a),
		.valid_a(valid_a),
		.data_b(data_b),
		.type_b(type_b),
		.any_dirty(any_dirty)
	);

	register_dumper u_dump (
		.clk(clk),
		.rst(rst),
		.dump_regs(dump_regs),
		.base(base),
		.data_a(data_a),
		.type_a(type_a),
		.dirty_a(dirty_a),
		.valid_a(valid_a),
		.mem_waitrequest(mem_waitrequest),
		.reg_idx(dump_idx),
		.dump_done(dump_done),
		.mem_address(dump_addr),
		.mem_writedata(dump_wdata),
		.mem_write(dump_write)
	);

	// requesters are never active together, idle ones drive zero
	assign mem_address = fu_addr | dump_addr;
	assign mem_writedata = fu_wdata | dump_wdata;
	assign mem_read = fu_read;
	assign mem_write = fu_write | dump_write;

endmodule

`default_nettype wire

// ==== lua_cpu_checker.sv ====
`default_nettype none
`include "lua_consts.svh"

module lua_cpu_checker (
	input wire clk,
	input wire rst,
	input wire start,
	input wire lua_pkg::host_cmd_t n,
	input wire lua_pkg::word_t dataa,
	input wire lua_pkg::word_t datab,
	input wire lua_pkg::word_t start_pc,
	input wire [127:0] prog,
	input wire lua_pkg::word_t exp_result,
	input wire done,
	input wire lua_pkg::word_t result,
	input wire lua_pkg::word_t mem_address,
	input wire lua_pkg::word_t mem_writedata,
	input wire mem_read,
	input wire mem_write,
	input wire mem_waitrequest,
	output int unsigned tests_run,
	output int unsigned tests_failed,
	output int unsigned error_count
);
	import lua_pkg::*;

	word_t m_data [`LUA_REG_COUNT];
	ttag_t m_tag [`LUA_REG_COUNT];
	logic [`LUA_REG_COUNT-1:0] m_valid;
	logic [`LUA_REG_COUNT-1:0] m_dirty;
	word_t m_base;
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	host_cmd_t cur_cmd;
	word_t cur_result;
	logic busy;
	int cycles;
	int unsigned errors_before;

	initial begin
		tests_run = 0;
		tests_failed = 0;
		error_count = 0;
		busy = 1'b0;
		m_base = '0;
	end

	task log_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		error_count++;
	endtask

	task report_counts();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
	endtask

	// reference model, also queues the memory writes a run must make
	task automatic replay_command();
		word_t off;
		word_t w;
		word_t pc;
		reg_idx_t a;
		reg_idx_t b;
		logic stopped;
		int i;
		off = (dataa - m_base) >> `LUA_TVALUE_SHIFT;
		case (n)
			CMD_LOAD_BASE: begin
				m_base = dataa;
				m_valid = '0;
				m_dirty = '0;
			end
			CMD_LOAD_REG: begin
				if (off < `LUA_REG_COUNT) begin
					m_data[off] = datab;
					m_valid[off] = 1'b1; // host load, stays clean
				end
			end
			CMD_LOAD_TT: begin
				if (off < `LUA_REG_COUNT)
					m_tag[off] = datab[`LUA_TTAG_BITS-1:0];
			end
			default: begin
				pc = start_pc;
				stopped = 1'b0;
				for (i = 0; i < 4; i++) begin
					w = prog[i*32 +: 32];
					if (!stopped) begin
						pc = pc + `LUA_INSTR_BYTES;
						if (w[5:0] == 6'd0) begin // MOVE A B
							a = w[11:6];
							b = w[28:23];
							m_data[a] = m_data[b];
							m_tag[a] = m_tag[b];
							m_valid[a] = 1'b1;
							m_dirty[a] = 1'b1;
						end else begin
							stopped = 1'b1;
						end
					end
				end
				exp_addr_q.push_back(datab + `LUA_SAVEDPC_OFFSET);
				exp_data_q.push_back(pc);
				for (i = 0; i < `LUA_REG_COUNT; i++) begin
					if (m_dirty[i] && m_valid[i]) begin
						exp_addr_q.push_back(m_base + (word_t'(i) << `LUA_TVALUE_SHIFT));
						exp_data_q.push_back(m_data[i]);
						exp_addr_q.push_back(m_base + (word_t'(i) << `LUA_TVALUE_SHIFT)
							+ `LUA_TYPE_OFFSET);
						exp_data_q.push_back(word_t'(m_tag[i]));
					end
				end
				m_dirty = '0;
			end
		endcase
	endtask

	always @(posedge clk) begin : watch
		word_t addr;
		word_t data;
		if (rst) begin
			if (done !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0 || result !== '0)
				log_error("outputs not cleared during reset");
			m_valid = '0;
			m_dirty = '0;
			m_base = '0;
			busy = 1'b0;
			exp_addr_q.delete();
			exp_data_q.delete();
		end else if (busy) begin
			cycles++;
			if (cur_cmd != CMD_RUN && (mem_read || mem_write))
				log_error("memory access during a load command");
			if (mem_write && !mem_waitrequest) begin
				if (exp_addr_q.size() == 0) begin
					log_error($sformatf("unexpected write of %h to %h",
						mem_writedata, mem_address));
				end else begin
					addr = exp_addr_q.pop_front();
					data = exp_data_q.pop_front();
					if (mem_address !== addr || mem_writedata !== data)
						log_error($sformatf("write of %h to %h, expected %h to %h",
							mem_writedata, mem_address, data, addr));
				end
			end
			if (done) begin
				if (cur_cmd != CMD_RUN && cycles != 2)
					log_error($sformatf("done came %0d cycles after start", cycles));
				if (exp_addr_q.size() != 0)
					log_error($sformatf("%0d memory writes missing", exp_addr_q.size()));
				if (result !== cur_result)
					log_error($sformatf("result %h, expected %h", result, cur_result));
				exp_addr_q.delete();
				exp_data_q.delete();
				tests_run++;
				if (error_count != errors_before) begin
					tests_failed++;
					$display("test %0d, command %0d: FAILED", tests_run, cur_cmd);
				end else begin
					$display("test %0d, command %0d: ok", tests_run, cur_cmd);
				end
				busy = 1'b0;
			end
		end else begin
			if (done || mem_read || mem_write)
				log_error("DUT active with no command pending");
			if (start) begin
				cur_cmd = n;
				cur_result = exp_result;
				errors_before = error_count;
				replay_command();
				cycles = 0;
				busy = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== lua_cpu_tb.sv ====
`default_nettype none
`include "lua_consts.svh"

module lua_cpu_tb;
	import lua_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NROWS = 13;
	localparam int PASSES = 2;
	localparam int ROW_CYCLES = 1500; // full dump with heavy stalls fits easily
	localparam int WATCHDOG_CYCLES = PASSES * (RESET_CYCLES + 2 + NROWS * ROW_CYCLES);

	localparam logic [31:0] OP_RET = 32'h0080_0026; // RETURN is not implemented
	localparam logic [31:0] OP_JUMP = 32'h0000_001E;
	localparam logic [31:0] OP_CALLF = 32'h0100_0024;

	logic clk;
	logic rst;
	logic start;
	host_cmd_t n;
	word_t dataa;
	word_t datab;
	word_t mem_readdata;
	logic mem_waitrequest;
	word_t result;
	logic done;
	word_t mem_address;
	word_t mem_writedata;
	logic mem_read;
	logic mem_write;
	word_t start_pc;
	logic [127:0] prog;
	word_t exp_result;
	logic random_wait;
	int unsigned tests_run;
	int unsigned tests_failed;
	int unsigned error_count;
	word_t mem [1024];

	host_cmd_t row_cmd [NROWS];
	word_t row_a [NROWS];
	word_t row_b [NROWS];
	word_t row_pc [NROWS];
	logic [127:0] row_prog [NROWS];
	word_t row_res [NROWS];
	int row_count;

	lua_cpu dut0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.n(n),
		.dataa(dataa),
		.datab(datab),
		.mem_readdata(mem_readdata),
		.mem_waitrequest(mem_waitrequest),
		.result(result),
		.done(done),
		.mem_address(mem_address),
		.mem_writedata(mem_writedata),
		.mem_read(mem_read),
		.mem_write(mem_write)
	);

	lua_cpu_checker chk0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.n(n),
		.dataa(dataa),
		.datab(datab),
		.start_pc(start_pc),
		.prog(prog),
		.exp_result(exp_result),
		.done(done),
		.result(result),
		.mem_address(mem_address),
		.mem_writedata(mem_writedata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_waitrequest(mem_waitrequest),
		.tests_run(tests_run),
		.tests_failed(tests_failed),
		.error_count(error_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// 4 KB word memory with combinational read
	assign mem_readdata = mem[mem_address[11:2]];

	always @(posedge clk) begin
		mem_waitrequest <= random_wait && ($urandom % 2 == 1);
		if (mem_write && !mem_waitrequest)
			mem[mem_address[11:2]] <= mem_writedata;
	end

	function automatic word_t encode_move(input reg_idx_t a, input reg_idx_t b);
		return (word_t'(b) << 23) | (word_t'(a) << 6);
	endfunction

	task automatic add_row(input host_cmd_t cmd, input word_t a, input word_t b,
			input word_t pc, input logic [127:0] p, input word_t res);
		row_cmd[row_count] = cmd;
		row_a[row_count] = a;
		row_b[row_count] = b;
		row_pc[row_count] = pc;
		row_prog[row_count] = p;
		row_res[row_count] = res;
		row_count++;
	endtask

	task automatic build_table();
		row_count = 0;
		add_row(CMD_LOAD_BASE, 32'h0000_0800, 32'h0, 32'h0, '0, 32'h0);
		add_row(CMD_LOAD_REG, 32'h0000_0810, 32'h1111_0002, 32'h0, '0, 32'h0); // r2
		add_row(CMD_LOAD_TT, 32'h0000_0810, 32'h0000_0003, 32'h0, '0, 32'h0);
		add_row(CMD_LOAD_REG, 32'h0000_0828, 32'h5555_0005, 32'h0, '0, 32'h0); // r5
		add_row(CMD_LOAD_TT, 32'h0000_0828, 32'hffff_ff93, 32'h0, '0, 32'h0);
		add_row(CMD_LOAD_REG, 32'h0000_0a28, 32'hdead_0064, 32'h0, '0, 32'h0); // slot 69
		add_row(CMD_LOAD_REG, 32'h0000_0610, 32'hbad0_0002, 32'h0, '0, 32'h0); // below base
		add_row(CMD_LOAD_REG, 32'h0000_09f8, 32'h6363_003f, 32'h0, '0, 32'h0); // r63
		add_row(CMD_LOAD_TT, 32'h0000_09f8, 32'h0000_0005, 32'h0, '0, 32'h0);
		add_row(CMD_RUN, 32'h0, 32'h0000_0100, 32'h0000_0200,
			{32'h0, 32'h0, 32'h0, OP_RET}, OP_RET);
		add_row(CMD_RUN, 32'h0, 32'h0000_0140, 32'h0000_0300,
			{OP_JUMP, encode_move(3, 10), encode_move(7, 5), encode_move(10, 2)}, OP_JUMP);
		add_row(CMD_LOAD_TT, 32'h0000_0810, 32'h0000_0004, 32'h0, '0, OP_JUMP);
		add_row(CMD_RUN, 32'h0, 32'h0000_0100, 32'h0000_0400,
			{OP_CALLF, encode_move(7, 0), encode_move(63, 2), encode_move(0, 63)}, OP_CALLF);
	endtask

	task automatic hold_reset();
		int i;
		@(posedge clk);
		rst <= 1'b1;
		for (i = 0; i < RESET_CYCLES; i++)
			@(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic apply_row(input int r);
		word_t addr;
		int i;
		if (row_cmd[r] == CMD_RUN) begin
			addr = row_b[r] + `LUA_SAVEDPC_OFFSET;
			mem[addr[11:2]] = row_pc[r];
			for (i = 0; i < 4; i++) begin
				addr = row_pc[r] + word_t'(i) * `LUA_INSTR_BYTES;
				mem[addr[11:2]] = row_prog[r][i*32 +: 32];
			end
		end
		@(posedge clk);
		start <= 1'b1;
		n <= row_cmd[r];
		dataa <= row_a[r];
		datab <= row_b[r];
		start_pc <= row_pc[r];
		prog <= row_prog[r];
		exp_result <= row_res[r];
		@(posedge clk);
		start <= 1'b0;
		do
			@(posedge clk);
		while (!done);
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the DUT never finished the command table");
		$display("tests failed");
		$finish;
	end

	initial begin : main
		int pass;
		int r;
		int i;
		void'($urandom(32'haab2_4c67));
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		n = CMD_RUN;
		dataa = '0;
		datab = '0;
		mem_waitrequest = 1'b0;
		random_wait = 1'b0;
		start_pc = '0;
		prog = '0;
		exp_result = '0;
		for (i = 0; i < 1024; i++)
			mem[i] = $urandom;
		build_table();
		for (pass = 0; pass < PASSES; pass++) begin
			random_wait <= (pass != 0); // second pass stalls the memory at random
			hold_reset();
			for (r = 0; r < row_count; r++)
				apply_row(r);
		end
		@(posedge clk);
		chk0.report_counts();
		if (tests_failed == 0 && error_count == 0 && tests_run == NROWS * PASSES) begin
			$display("all tests passed");
		end else begin
			if (tests_run != NROWS * PASSES)
				$display("only %0d of %0d commands completed", tests_run, NROWS * PASSES);
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
lua_pkg.sv
fetch_unit.sv
instr_exec.sv
register_file.sv
reg_port_a_select.sv
register_dumper.sv
main_sequencer.sv
lua_cpu.sv
lua_cpu_checker.sv
lua_cpu_tb.sv
